//--- Makefile
# Verilator flow for eth_lite; override any variable on the command line.
VERILATOR ?= verilator
TOP       ?= eth_lite_tb
FLIST     ?= eth_lite.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= Test failed
PASS_MSG  ?= Test completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- common/eth_consts.svh
`ifndef ETH_CONSTS_SVH
`define ETH_CONSTS_SVH

`define ETH_FIFO_DEPTH  512
`define ETH_MIN_PAYLOAD 46
`define ETH_GAP         12
`define ETH_ETYPE_ARP   16'h0806

// apb register map.
`define REG_MAC_LO   8'h00
`define REG_MAC_HI   8'h04
`define REG_IPV4     8'h08
`define REG_TX_CNT   8'h0C
`define REG_ARP_CNT  8'h10
`define REG_DROP_CNT 8'h14

`endif

//--- common/eth_pkg.sv
`default_nettype none

package eth_pkg;

	typedef logic [47:0] mac_addr_t;
	typedef logic [31:0] ipv4_t;
	typedef logic [15:0] ethertype_t;

	// arp operation field.
	typedef enum logic [15:0] {
		ARP_REQUEST = 16'd1,
		ARP_REPLY   = 16'd2
	} arp_op_e;

endpackage : eth_pkg

`default_nettype wire

//--- common/mac_pkg.sv
`default_nettype none

package mac_pkg;

	// dst goes out on the wire first and etype last.
	typedef struct packed {
		eth_pkg::mac_addr_t  dst;
		eth_pkg::mac_addr_t  src;
		eth_pkg::ethertype_t etype;
	} mac_hdr_t;

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_PRE,
		TX_HDR,
		TX_PAY,
		TX_PAD,
		TX_FCS,
		TX_GAP
	} tx_state_e;

	typedef enum logic [1:0] {
		ST_PARSE,
		ST_CHECK,
		ST_REPLY,
		ST_SKIP
	} arp_state_e;

endpackage : mac_pkg

`default_nettype wire

//--- eth_lite.f
+incdir+common
common/eth_pkg.sv
common/mac_pkg.sv
hw/eth_regs.sv
hw/arp/arp_responder.sv
hw/buf_mng.sv
hw/mac/mac_tx_framer.sv
hw/eth_lite.sv
testbench/eth_lite_tb.sv

//--- hw/arp/arp_responder.sv
`timescale 1ns/1ns
`default_nettype none

`include "eth_consts.svh"

module arp_responder (
	input  logic               clk,
	input  logic               rst,
	input  logic [7:0]         rx_d,
	input  logic               rx_v,
	input  logic               rx_eof,
	input  eth_pkg::mac_addr_t dev_mac,
	input  eth_pkg::ipv4_t     dev_ipv4,
	input  logic [9:0]         ch0_space,
	output logic [7:0]         ch0_d,
	output logic               ch0_v,
	output logic               ch0_eof,
	output mac_pkg::mac_hdr_t  ch0_hdr,
	output logic               arp_sent,
	output logic               arp_drop
);

localparam int ARP_LEN = 28;
localparam int MIN_LEN = 42; // mac header plus arp body.

mac_pkg::arp_state_e  state;
logic [5:0]           cnt;
logic                 full;
eth_pkg::ethertype_t  etype;
logic [15:0]          oper;
eth_pkg::mac_addr_t   sha;
eth_pkg::ipv4_t       spa;
eth_pkg::ipv4_t       tpa;
logic [4:0]           ridx;
logic [ARP_LEN*8-1:0] reply;
logic                 match;
logic                 room;

// byte position within the rx frame.
always_ff @(posedge clk) begin
	if (rst) begin
		cnt <= '0;
	end else if (rx_v) begin
		if (rx_eof)
			cnt <= '0;
		else if (cnt != '1)
			cnt <= cnt + 6'd1;
	end
end

////////////////////
// field capture
////////////////////
always_ff @(posedge clk) begin
	if (state == mac_pkg::ST_PARSE && rx_v) begin
		case (cnt) inside
			[6'd12:6'd13]: etype <= {etype[7:0], rx_d};
			[6'd20:6'd21]: oper  <= {oper[7:0], rx_d};
			[6'd22:6'd27]: sha   <= {sha[39:0], rx_d};
			[6'd28:6'd31]: spa   <= {spa[23:0], rx_d};
			[6'd38:6'd41]: tpa   <= {tpa[23:0], rx_d};
			default: ;
		endcase
	end
end

assign match = full && etype == `ETH_ETYPE_ARP && oper == eth_pkg::ARP_REQUEST &&
	tpa == dev_ipv4;
assign room  = ch0_space >= 10'(ARP_LEN);

// htype, ptype, hlen, plen, op, sender, target.
assign reply = {16'h0001, 16'h0800, 8'd6, 8'd4, eth_pkg::ARP_REPLY,
	dev_mac, dev_ipv4, sha, spa};

////////////////////
// control
////////////////////
always_ff @(posedge clk) begin
	if (rst) begin
		state    <= mac_pkg::ST_PARSE;
		full     <= 1'b0;
		ridx     <= '0;
		ch0_v    <= 1'b0;
		ch0_eof  <= 1'b0;
		arp_sent <= 1'b0;
		arp_drop <= 1'b0;
	end else begin
		arp_sent <= 1'b0;
		arp_drop <= 1'b0;
		case (state)
			mac_pkg::ST_PARSE: begin
				if (rx_v && rx_eof) begin
					full  <= cnt >= 6'(MIN_LEN - 1);
					state <= mac_pkg::ST_CHECK;
				end else if (rx_v && cnt == 6'd13 && {etype[7:0], rx_d} != `ETH_ETYPE_ARP) begin
					state <= mac_pkg::ST_SKIP; // not arp.
				end
			end
			mac_pkg::ST_CHECK: begin
				if (match && room) begin
					ch0_v <= 1'b1;
					ridx  <= 5'd1;
					state <= mac_pkg::ST_REPLY;
				end else begin
					arp_drop <= match;
					state    <= mac_pkg::ST_PARSE;
				end
			end
			mac_pkg::ST_REPLY: begin
				if (ridx == 5'(ARP_LEN)) begin
					ch0_v   <= 1'b0;
					ch0_eof <= 1'b0;
					ridx    <= '0;
					// a frame that began mid reply is lost.
					if (cnt != '0 && !(rx_v && rx_eof))
						state <= mac_pkg::ST_SKIP;
					else
						state <= mac_pkg::ST_PARSE;
				end else begin
					ch0_eof  <= ridx == 5'(ARP_LEN - 1);
					arp_sent <= ridx == 5'(ARP_LEN - 1);
					ridx     <= ridx + 5'd1;
				end
			end
			mac_pkg::ST_SKIP: begin
				if (rx_v && rx_eof)
					state <= mac_pkg::ST_PARSE;
			end
			default: state <= mac_pkg::ST_PARSE;
		endcase
	end
end

always_ff @(posedge clk) begin
	if (state == mac_pkg::ST_CHECK)
		ch0_hdr <= '{dst: sha, src: dev_mac, etype: `ETH_ETYPE_ARP};
	if ((state == mac_pkg::ST_CHECK || state == mac_pkg::ST_REPLY) && ridx < 5'(ARP_LEN))
		ch0_d <= reply[(ARP_LEN*8-1) - 8*ridx -: 8];
end

a_no_tx_in_parse: assert property (@(posedge clk) disable iff (rst)
	state == mac_pkg::ST_PARSE |-> !ch0_v);

endmodule

`default_nettype wire

//--- hw/buf_mng.sv
`timescale 1ns/1ns
`default_nettype none

`include "eth_consts.svh"

module buf_mng (
	input  logic                clk,
	input  logic                rst,
	input  logic [7:0]          ch0_d,
	input  logic                ch0_v,
	input  logic                ch0_eof,
	input  mac_pkg::mac_hdr_t   ch0_hdr,
	output logic [9:0]          ch0_space,
	input  logic [7:0]          usr_d,
	input  logic                usr_v,
	input  logic                usr_eof,
	input  eth_pkg::mac_addr_t  usr_dst,
	input  eth_pkg::ethertype_t usr_type,
	output logic                usr_rdy,
	output logic [7:0]          pl_d,
	output logic                pl_v,
	output logic                pl_last,
	output mac_pkg::mac_hdr_t   pl_hdr,
	input  logic                pl_ack
);

localparam int DEPTH = `ETH_FIFO_DEPTH;
localparam int AW    = $clog2(DEPTH);
localparam int HQ    = 4; // headers per channel.

logic [8:0]        mem      [2][DEPTH]; // {eof, data}.
mac_pkg::mac_hdr_t hq       [2][HQ];
logic [AW-1:0]     wptr     [2];
logic [AW-1:0]     rptr     [2];
logic [AW:0]       fill     [2];
logic [AW:0]       free     [2];
logic [1:0]        hwp      [2];
logic [1:0]        hrp      [2];
logic [2:0]        hcnt     [2];
logic [2:0]        frames   [2];
logic              in_frame [2];
logic              wr       [2];
logic              rd       [2];
logic              done     [2];
logic [8:0]        wdat     [2];
mac_pkg::mac_hdr_t whdr     [2];
logic              busy;
logic              sel;
logic              last_sel;

always_comb begin
	wr[0]   = ch0_v;
	wr[1]   = usr_v && usr_rdy;
	wdat[0] = {ch0_eof, ch0_d};
	wdat[1] = {usr_eof, usr_d};
	whdr[0] = ch0_hdr;
	whdr[1] = '{dst: usr_dst, src: '0, etype: usr_type}; // src filled by framer.
	for (int c = 0; c < 2; c++) begin
		rd[c]   = busy && pl_ack && sel == 1'(c);
		done[c] = rd[c] && pl_last;
		free[c] = (AW+1)'(DEPTH) - fill[c];
	end
end

assign ch0_space = (hcnt[0] == 3'(HQ)) ? '0 : free[0];
assign usr_rdy   = free[1] >= (AW+1)'(2) && !(hcnt[1] == 3'(HQ) && !in_frame[1]);

assign pl_v    = busy;
assign pl_d    = mem[sel][rptr[sel]][7:0];
assign pl_last = mem[sel][rptr[sel]][8];
assign pl_hdr  = hq[sel][hrp[sel]];

always_ff @(posedge clk) begin
	for (int c = 0; c < 2; c++) begin
		if (wr[c])
			mem[c][wptr[c]] <= wdat[c];
		if (wr[c] && !in_frame[c])
			hq[c][hwp[c]] <= whdr[c];
	end
end

////////////////////
// pointers and counts
////////////////////
always_ff @(posedge clk) begin
	if (rst) begin
		for (int c = 0; c < 2; c++) begin
			wptr[c]     <= '0;
			rptr[c]     <= '0;
			fill[c]     <= '0;
			hwp[c]      <= '0;
			hrp[c]      <= '0;
			hcnt[c]     <= '0;
			frames[c]   <= '0;
			in_frame[c] <= 1'b0;
		end
	end else begin
		for (int c = 0; c < 2; c++) begin
			if (wr[c]) begin
				wptr[c]     <= wptr[c] + AW'(1);
				in_frame[c] <= !wdat[c][8];
			end
			if (rd[c])
				rptr[c] <= rptr[c] + AW'(1);
			if (wr[c] && !in_frame[c])
				hwp[c] <= hwp[c] + 2'd1;
			if (done[c])
				hrp[c] <= hrp[c] + 2'd1;
			fill[c]   <= fill[c] + (AW+1)'(wr[c]) - (AW+1)'(rd[c]);
			hcnt[c]   <= hcnt[c] + 3'(wr[c] && !in_frame[c]) - 3'(done[c]);
			frames[c] <= frames[c] + 3'(wr[c] && wdat[c][8]) - 3'(done[c]);
		end
	end
end

// whole-frame round robin.
always_ff @(posedge clk) begin
	if (rst) begin
		busy     <= 1'b0;
		sel      <= 1'b0;
		last_sel <= 1'b1; // channel 0 wins first tie.
	end else if (busy) begin
		if (pl_ack && pl_last) begin
			busy     <= 1'b0;
			last_sel <= sel;
		end
	end else if (frames[0] != '0 || frames[1] != '0) begin
		busy <= 1'b1;
		if (frames[0] != '0 && frames[1] != '0)
			sel <= !last_sel;
		else
			sel <= frames[1] != '0;
	end
end

a_no_overflow: assert property (@(posedge clk) disable iff (rst)
	!((wr[0] && fill[0] == (AW+1)'(DEPTH)) || (wr[1] && fill[1] == (AW+1)'(DEPTH))));

endmodule

`default_nettype wire

//--- hw/eth_lite.sv
`timescale 1ns/1ns
`default_nettype none

module eth_lite (
	input  logic                clk,
	input  logic                rst,
	input  logic                psel,
	input  logic                penable,
	input  logic                pwrite,
	input  logic [7:0]          paddr,
	input  logic [31:0]         pwdata,
	output logic [31:0]         prdata,
	output logic                pready,
	output logic                pslverr,
	input  logic [7:0]          rx_d,
	input  logic                rx_v,
	input  logic                rx_eof,
	input  logic [7:0]          usr_d,
	input  logic                usr_v,
	input  logic                usr_eof,
	output logic                usr_rdy,
	input  eth_pkg::mac_addr_t  usr_dst,
	input  eth_pkg::ethertype_t usr_type,
	output logic [7:0]          phy_d,
	output logic                phy_v
);

eth_pkg::mac_addr_t dev_mac;
eth_pkg::ipv4_t     dev_ipv4;
logic [7:0]         ch0_d;
logic               ch0_v;
logic               ch0_eof;
mac_pkg::mac_hdr_t  ch0_hdr;
logic [9:0]         ch0_space;
logic [7:0]         pl_d;
logic               pl_v;
logic               pl_last;
mac_pkg::mac_hdr_t  pl_hdr;
logic               pl_ack;
logic               frame_sent;
logic               arp_sent;
logic               arp_drop;

eth_regs eth_regs_i (
	.clk        (clk),
	.rst        (rst),
	.psel       (psel),
	.penable    (penable),
	.pwrite     (pwrite),
	.paddr      (paddr),
	.pwdata     (pwdata),
	.prdata     (prdata),
	.pready     (pready),
	.pslverr    (pslverr),
	.frame_sent (frame_sent),
	.arp_sent   (arp_sent),
	.arp_drop   (arp_drop),
	.dev_mac    (dev_mac),
	.dev_ipv4   (dev_ipv4)
);

arp_responder arp_responder_i (
	.clk       (clk),
	.rst       (rst),
	.rx_d      (rx_d),
	.rx_v      (rx_v),
	.rx_eof    (rx_eof),
	.dev_mac   (dev_mac),
	.dev_ipv4  (dev_ipv4),
	.ch0_space (ch0_space),
	.ch0_d     (ch0_d),
	.ch0_v     (ch0_v),
	.ch0_eof   (ch0_eof),
	.ch0_hdr   (ch0_hdr),
	.arp_sent  (arp_sent),
	.arp_drop  (arp_drop)
);

// channel 0 is arp, channel 1 is the user port.
buf_mng buf_mng_i (
	.clk       (clk),
	.rst       (rst),
	.ch0_d     (ch0_d),
	.ch0_v     (ch0_v),
	.ch0_eof   (ch0_eof),
	.ch0_hdr   (ch0_hdr),
	.ch0_space (ch0_space),
	.usr_d     (usr_d),
	.usr_v     (usr_v),
	.usr_eof   (usr_eof),
	.usr_dst   (usr_dst),
	.usr_type  (usr_type),
	.usr_rdy   (usr_rdy),
	.pl_d      (pl_d),
	.pl_v      (pl_v),
	.pl_last   (pl_last),
	.pl_hdr    (pl_hdr),
	.pl_ack    (pl_ack)
);

mac_tx_framer mac_tx_framer_i (
	.clk        (clk),
	.rst        (rst),
	.dev_mac    (dev_mac),
	.pl_d       (pl_d),
	.pl_v       (pl_v),
	.pl_last    (pl_last),
	.pl_hdr     (pl_hdr),
	.pl_ack     (pl_ack),
	.phy_d      (phy_d),
	.phy_v      (phy_v),
	.frame_sent (frame_sent)
);

endmodule

`default_nettype wire

//--- hw/eth_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "eth_consts.svh"

module eth_regs (
	input  logic               clk,
	input  logic               rst,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  logic [7:0]         paddr,
	input  logic [31:0]        pwdata,
	output logic [31:0]        prdata,
	output logic               pready,
	output logic               pslverr,
	input  logic               frame_sent,
	input  logic               arp_sent,
	input  logic               arp_drop,
	output eth_pkg::mac_addr_t dev_mac,
	output eth_pkg::ipv4_t     dev_ipv4
);

logic        access;
logic        mapped;
logic [31:0] tx_cnt;
logic [31:0] arp_cnt;
logic [31:0] drop_cnt;

function automatic logic [31:0] sat_inc(input logic [31:0] v, input logic en);
	return (en && v != '1) ? v + 32'd1 : v;
endfunction

assign access = psel && penable;
assign pready = 1'b1; // zero wait states.

always_comb begin
	mapped = 1'b1;
	prdata = '0;
	case (paddr)
		`REG_MAC_LO:   prdata = dev_mac[31:0];
		`REG_MAC_HI:   prdata = {16'h0000, dev_mac[47:32]};
		`REG_IPV4:     prdata = dev_ipv4;
		`REG_TX_CNT:   prdata = tx_cnt;
		`REG_ARP_CNT:  prdata = arp_cnt;
		`REG_DROP_CNT: prdata = drop_cnt;
		default:       mapped = 1'b0;
	endcase
end

assign pslverr = access && !mapped;

always_ff @(posedge clk) begin
	if (rst) begin
		dev_mac  <= '0;
		dev_ipv4 <= '0;
	end else if (access && pwrite) begin
		case (paddr)
			`REG_MAC_LO: dev_mac[31:0]  <= pwdata;
			`REG_MAC_HI: dev_mac[47:32] <= pwdata[15:0];
			`REG_IPV4:   dev_ipv4       <= pwdata;
			default: ; // counters are read only.
		endcase
	end
end

always_ff @(posedge clk) begin
	if (rst) begin
		tx_cnt   <= '0;
		arp_cnt  <= '0;
		drop_cnt <= '0;
	end else begin
		tx_cnt   <= sat_inc(tx_cnt, frame_sent);
		arp_cnt  <= sat_inc(arp_cnt, arp_sent);
		drop_cnt <= sat_inc(drop_cnt, arp_drop);
	end
end

a_apb_phase: assert property (@(posedge clk) disable iff (rst) penable |-> psel);

endmodule

`default_nettype wire

//--- hw/mac/mac_tx_framer.sv
`timescale 1ns/1ns
`default_nettype none

`include "eth_consts.svh"

module mac_tx_framer (
	input  logic               clk,
	input  logic               rst,
	input  eth_pkg::mac_addr_t dev_mac,
	input  logic [7:0]         pl_d,
	input  logic               pl_v,
	input  logic               pl_last,
	input  mac_pkg::mac_hdr_t  pl_hdr,
	output logic               pl_ack,
	output logic [7:0]         phy_d,
	output logic               phy_v,
	output logic               frame_sent
);

localparam int MIN_PAY = `ETH_MIN_PAYLOAD;
localparam int GAP     = `ETH_GAP;

mac_pkg::tx_state_e state;
logic [3:0]         cnt;
logic [5:0]         plen;
logic [111:0]       hdr_sh;
logic [31:0]        crc;

// one byte of reflected crc-32.
function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
	logic [31:0] r;
	r = c ^ {24'h000000, d};
	for (int i = 0; i < 8; i++) begin
		r = r[0] ? ((r >> 1) ^ 32'hEDB8_8320) : (r >> 1);
	end
	return r;
endfunction

assign pl_ack = state == mac_pkg::TX_PAY;

////////////////////
// control
////////////////////
always_ff @(posedge clk) begin
	if (rst) begin
		state      <= mac_pkg::TX_IDLE;
		cnt        <= '0;
		plen       <= '0;
		phy_v      <= 1'b0;
		frame_sent <= 1'b0;
	end else begin
		frame_sent <= 1'b0;
		case (state)
			mac_pkg::TX_IDLE: begin
				phy_v <= 1'b0;
				cnt   <= '0;
				if (pl_v)
					state <= mac_pkg::TX_PRE;
			end
			mac_pkg::TX_PRE: begin
				phy_v <= 1'b1;
				cnt   <= cnt + 4'd1;
				if (cnt == 4'd7) begin
					cnt   <= '0;
					state <= mac_pkg::TX_HDR;
				end
			end
			mac_pkg::TX_HDR: begin
				cnt  <= cnt + 4'd1;
				plen <= '0;
				if (cnt == 4'd13) begin
					cnt   <= '0;
					state <= mac_pkg::TX_PAY;
				end
			end
			mac_pkg::TX_PAY: begin
				if (plen != '1)
					plen <= plen + 6'd1;
				if (pl_last)
					state <= (plen < 6'(MIN_PAY - 1)) ? mac_pkg::TX_PAD : mac_pkg::TX_FCS;
			end
			mac_pkg::TX_PAD: begin
				plen <= plen + 6'd1;
				if (plen == 6'(MIN_PAY - 1))
					state <= mac_pkg::TX_FCS;
			end
			mac_pkg::TX_FCS: begin
				cnt <= cnt + 4'd1;
				if (cnt == 4'd3) begin
					cnt        <= '0;
					frame_sent <= 1'b1;
					state      <= mac_pkg::TX_GAP;
				end
			end
			mac_pkg::TX_GAP: begin
				phy_v <= 1'b0;
				cnt   <= cnt + 4'd1;
				if (cnt == 4'(GAP - 2)) // idle adds the last gap cycle.
					state <= mac_pkg::TX_IDLE;
			end
			default: state <= mac_pkg::TX_IDLE;
		endcase
	end
end

////////////////////
// datapath
////////////////////
always_ff @(posedge clk) begin
	case (state)
		mac_pkg::TX_IDLE: begin
			phy_d  <= 8'h00;
			hdr_sh <= {pl_hdr.dst, dev_mac, pl_hdr.etype}; // our mac as source.
		end
		mac_pkg::TX_PRE: begin
			phy_d <= (cnt == 4'd7) ? 8'hD5 : 8'h55;
			crc   <= '1;
		end
		mac_pkg::TX_HDR: begin
			phy_d  <= hdr_sh[111:104];
			hdr_sh <= hdr_sh << 8;
			crc    <= crc_byte(crc, hdr_sh[111:104]);
		end
		mac_pkg::TX_PAY: begin
			phy_d <= pl_d;
			crc   <= crc_byte(crc, pl_d);
		end
		mac_pkg::TX_PAD: begin
			phy_d <= 8'h00;
			crc   <= crc_byte(crc, 8'h00);
		end
		mac_pkg::TX_FCS: begin
			phy_d <= ~crc[7:0]; // lsb first.
			crc   <= crc >> 8;
		end
		default: phy_d <= 8'h00;
	endcase
end

a_ack_valid: assert property (@(posedge clk) disable iff (rst) pl_ack |-> pl_v);

endmodule

`default_nettype wire

//--- testbench/eth_lite_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "eth_consts.svh"

module eth_lite_tb;

localparam int          CLK_PERIOD = 40;
localparam int          TEST_BYTES = 10 + 200 + 4 * 42 + 30 + 10 * 24;
localparam longint      TIMEOUT_NS = longint'(TEST_BYTES) * CLK_PERIOD * 4 + 100_000;
localparam logic [47:0] MY_MAC     = 48'h02_60_8c_12_34_56;
localparam logic [31:0] MY_IPV4    = 32'hc0_a8_01_0a;
localparam logic [47:0] PEER_MAC   = 48'h02_11_22_33_44_55;
localparam logic [31:0] PEER_IPV4  = 32'hc0_a8_01_14;
localparam logic [47:0] USR_DST    = 48'h02_aa_bb_cc_dd_ee;

typedef logic [7:0] byte_q_t [$];

logic                clk;
logic                rst;
logic                psel;
logic                penable;
logic                pwrite;
logic [7:0]          paddr;
logic [31:0]         pwdata;
logic [31:0]         prdata;
logic                pready;
logic                pslverr;
logic [7:0]          rx_d;
logic                rx_v;
logic                rx_eof;
logic [7:0]          usr_d;
logic                usr_v;
logic                usr_eof;
logic                usr_rdy;
eth_pkg::mac_addr_t  usr_dst;
eth_pkg::ethertype_t usr_type;
logic [7:0]          phy_d;
logic                phy_v;

string   test_name = "reset";
byte_q_t arp_b;
byte_q_t usr_b;
int      arp_n [$];
int      usr_n [$];
byte_q_t got;
int      exp_tx = 0;
int      exp_arp = 0;
int      exp_drop = 0; // channel 0 never backs up in these tests.
int      mism = 0;
int      fails = 0;
int      phy_mism = 0;
int      phy_fails = 0;
int      frames_seen = 0;
int      gap_len = 0;
int      last_gap = 0;
logic    phy_v_q = 1'b0;
logic    saw_stall = 1'b0;

eth_lite dut_i (
	.clk      (clk),
	.rst      (rst),
	.psel     (psel),
	.penable  (penable),
	.pwrite   (pwrite),
	.paddr    (paddr),
	.pwdata   (pwdata),
	.prdata   (prdata),
	.pready   (pready),
	.pslverr  (pslverr),
	.rx_d     (rx_d),
	.rx_v     (rx_v),
	.rx_eof   (rx_eof),
	.usr_d    (usr_d),
	.usr_v    (usr_v),
	.usr_eof  (usr_eof),
	.usr_rdy  (usr_rdy),
	.usr_dst  (usr_dst),
	.usr_type (usr_type),
	.phy_d    (phy_d),
	.phy_v    (phy_v)
);

always #(CLK_PERIOD / 2) clk = ~clk;

////////////////////
// reference model
////////////////////

// whole phy byte stream for one frame.
function automatic byte_q_t ref_frame(input logic [47:0] dst, input logic [47:0] src,
	input logic [15:0] etype, input byte_q_t pay);
	byte_q_t     body;
	byte_q_t     f;
	logic [31:0] crc;
	logic        fb;
	for (int i = 0; i < 6; i++)
		body.push_back(dst[47 - 8*i -: 8]);
	for (int i = 0; i < 6; i++)
		body.push_back(src[47 - 8*i -: 8]);
	body.push_back(etype[15:8]);
	body.push_back(etype[7:0]);
	foreach (pay[i])
		body.push_back(pay[i]);
	while (body.size() < 14 + `ETH_MIN_PAYLOAD)
		body.push_back(8'h00);
	crc = 32'hffff_ffff;
	foreach (body[i]) begin
		for (int b = 0; b < 8; b++) begin
			fb  = crc[0] ^ body[i][b]; // lsb of each byte goes first.
			crc = {1'b0, crc[31:1]} ^ (fb ? 32'hedb8_8320 : 32'h0);
		end
	end
	crc = ~crc;
	for (int i = 0; i < 7; i++)
		f.push_back(8'h55);
	f.push_back(8'hd5);
	foreach (body[i])
		f.push_back(body[i]);
	for (int i = 0; i < 4; i++)
		f.push_back(crc[8*i +: 8]);
	return f;
endfunction

function automatic byte_q_t arp_request(input logic [47:0] sha, input logic [31:0] spa,
	input logic [31:0] tpa);
	byte_q_t      f;
	logic [335:0] bits;
	bits = {48'hffff_ffff_ffff, sha, 16'h0806, 16'h0001, 16'h0800, 8'd6, 8'd4, 16'd1,
		sha, spa, 48'h0, tpa};
	for (int i = 0; i < 42; i++)
		f.push_back(bits[335 - 8*i -: 8]);
	return f;
endfunction

// arp body of the reply to a requester.
function automatic byte_q_t arp_reply_body(input logic [47:0] tha, input logic [31:0] tpa);
	byte_q_t      f;
	logic [223:0] bits;
	bits = {16'h0001, 16'h0800, 8'd6, 8'd4, 16'd2, MY_MAC, MY_IPV4, tha, tpa};
	for (int i = 0; i < 28; i++)
		f.push_back(bits[223 - 8*i -: 8]);
	return f;
endfunction

function automatic byte_q_t random_payload(input int n);
	byte_q_t p;
	for (int i = 0; i < n; i++)
		p.push_back(8'($urandom));
	return p;
endfunction

task automatic expect_frame(input bit is_arp, input byte_q_t f);
	foreach (f[i]) begin
		if (is_arp)
			arp_b.push_back(f[i]);
		else
			usr_b.push_back(f[i]);
	end
	if (is_arp) begin
		arp_n.push_back(f.size());
		exp_arp++;
	end else begin
		usr_n.push_back(f.size());
	end
	exp_tx++;
endtask

task automatic log_mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
	$display("ERR %s %s: expected 0x%0h, actual 0x%0h", test_name, what, exp, act);
endtask

task automatic log_failure(input string msg);
	$display("FAIL %s: %s", test_name, msg);
endtask

////////////////////
// stimulus
////////////////////

task automatic apb_write(input logic [7:0] a, input logic [31:0] d);
	@(negedge clk);
	psel    = 1'b1;
	penable = 1'b0;
	pwrite  = 1'b1;
	paddr   = a;
	pwdata  = d;
	@(negedge clk);
	penable = 1'b1;
	@(negedge clk);
	psel    = 1'b0;
	penable = 1'b0;
	pwrite  = 1'b0;
endtask

task automatic apb_read(input logic [7:0] a, output logic [31:0] d, output logic err);
	@(negedge clk);
	psel    = 1'b1;
	penable = 1'b0;
	pwrite  = 1'b0;
	paddr   = a;
	@(negedge clk);
	penable = 1'b1;
	#(CLK_PERIOD / 4); // mid access cycle.
	d   = prdata;
	err = pslverr;
	if (pready !== 1'b1) begin
		log_failure("pready was low in the access cycle");
		fails++;
	end
	@(negedge clk);
	psel    = 1'b0;
	penable = 1'b0;
endtask

task automatic send_rx(input byte_q_t f);
	foreach (f[i]) begin
		@(negedge clk);
		rx_v   = 1'b1;
		rx_d   = f[i];
		rx_eof = i == f.size() - 1;
	end
	@(negedge clk);
	rx_v   = 1'b0;
	rx_eof = 1'b0;
	repeat (40) @(negedge clk); // room for the reply write.
endtask

task automatic send_usr(input logic [47:0] dst, input logic [15:0] etype, input byte_q_t pay,
	input bit gaps);
	int i;
	i = 0;
	while (i < pay.size()) begin
		@(negedge clk);
		if (gaps && $urandom_range(3, 0) == 0) begin
			usr_v = 1'b0;
		end else begin
			usr_v    = 1'b1;
			usr_d    = pay[i];
			usr_eof  = i == pay.size() - 1;
			usr_dst  = dst;
			usr_type = etype;
			if (usr_rdy)
				i++; // taken at the next rising edge.
			else
				saw_stall = 1'b1;
		end
	end
	@(negedge clk);
	usr_v   = 1'b0;
	usr_eof = 1'b0;
endtask

task automatic wait_idle();
	while (arp_n.size() != 0 || usr_n.size() != 0 || phy_v)
		@(negedge clk);
	repeat (`ETH_GAP + 4) @(negedge clk);
endtask

////////////////////
// phy checker
////////////////////

task automatic match_frame();
	byte_q_t     exp;
	logic [15:0] etype;
	bit          is_arp;
	bit          bad;
	int          n;
	if (got.size() < 22) begin
		log_failure($sformatf("PHY frame of %0d bytes is too short for a header", got.size()));
		phy_fails++;
	end else begin
		etype  = {got[20], got[21]};
		is_arp = etype == `ETH_ETYPE_ARP;
		if ((is_arp && arp_n.size() == 0) || (!is_arp && usr_n.size() == 0)) begin
			log_failure($sformatf("unexpected PHY frame with ethertype %h", etype));
			phy_fails++;
		end else begin
			if (is_arp) begin
				n = arp_n.pop_front();
				repeat (n) exp.push_back(arp_b.pop_front());
			end else begin
				n = usr_n.pop_front();
				repeat (n) exp.push_back(usr_b.pop_front());
			end
			bad = 1'b0;
			if (n != got.size()) begin
				log_mismatch("frame length", 32'(n), 32'(got.size()));
				bad = 1'b1;
			end
			for (int i = 0; i < n && i < got.size() && !bad; i++) begin
				if (got[i] != exp[i]) begin
					log_mismatch($sformatf("byte %0d", i), 32'(exp[i]), 32'(got[i]));
					bad = 1'b1;
				end
			end
			if (bad)
				phy_mism++;
		end
	end
	got.delete();
endtask

always @(negedge clk) begin
	if (rst) begin
		phy_v_q = 1'b0;
		gap_len = 0;
	end else begin
		if (phy_v) begin
			if (!phy_v_q && frames_seen > 0) begin
				last_gap = gap_len;
				if (gap_len < `ETH_GAP) begin
					log_failure($sformatf("gap of %0d cycles before frame %0d is too short",
						gap_len, frames_seen));
					phy_fails++;
				end
			end
			got.push_back(phy_d);
		end else if (phy_v_q) begin
			match_frame();
			frames_seen++;
			gap_len = 1;
		end else begin
			gap_len++;
		end
		phy_v_q = phy_v;
	end
end

initial begin
	#(TIMEOUT_NS);
	$display("watchdog expired after %0d ns with frames still outstanding", TIMEOUT_NS);
	$display("Test failed");
	$finish;
end

////////////////////
// test sequence
////////////////////

initial begin
	logic [31:0] rd;
	logic        err;
	logic [7:0]  cnt_addr [3];
	byte_q_t     pay;
	int          seen;
	void'($urandom(32'he45b_0d04));
	cnt_addr = '{`REG_TX_CNT, `REG_ARP_CNT, `REG_DROP_CNT};
	clk      = 1'b0;
	rst      = 1'b1;
	psel     = 1'b0;
	penable  = 1'b0;
	pwrite   = 1'b0;
	paddr    = '0;
	pwdata   = '0;
	rx_d     = '0;
	rx_v     = 1'b0;
	rx_eof   = 1'b0;
	usr_d    = '0;
	usr_v    = 1'b0;
	usr_eof  = 1'b0;
	usr_dst  = '0;
	usr_type = '0;
	repeat (5) @(negedge clk);
	rst = 1'b0;
	@(negedge clk);

	test_name = "apb";
	if (phy_v !== 1'b0 || usr_rdy !== 1'b1 || pslverr !== 1'b0) begin
		log_failure("outputs are not idle after reset");
		fails++;
	end
	foreach (cnt_addr[i]) begin
		apb_read(cnt_addr[i], rd, err);
		if (rd != 32'h0 || err) begin
			log_mismatch($sformatf("counter 0x%0h after reset", cnt_addr[i]), 32'h0, rd);
			mism++;
		end
	end
	apb_write(`REG_MAC_LO, MY_MAC[31:0]);
	apb_write(`REG_MAC_HI, {16'h0000, MY_MAC[47:32]});
	apb_write(`REG_IPV4, MY_IPV4);
	apb_read(`REG_MAC_LO, rd, err);
	if (rd != MY_MAC[31:0] || err) begin
		log_mismatch("mac_lo", MY_MAC[31:0], rd);
		mism++;
	end
	apb_read(`REG_MAC_HI, rd, err);
	if (rd != {16'h0000, MY_MAC[47:32]} || err) begin
		log_mismatch("mac_hi", {16'h0000, MY_MAC[47:32]}, rd);
		mism++;
	end
	apb_read(`REG_IPV4, rd, err);
	if (rd != MY_IPV4 || err) begin
		log_mismatch("ipv4", MY_IPV4, rd);
		mism++;
	end
	apb_read(8'h18, rd, err);
	if (!err) begin
		log_failure("read of unmapped address 0x18 did not raise pslverr");
		fails++;
	end
	apb_write(`REG_TX_CNT, 32'h0000_1234); // read only.
	apb_read(`REG_TX_CNT, rd, err);
	if (rd != 32'h0) begin
		log_mismatch("tx_cnt after write", 32'h0, rd);
		mism++;
	end

	test_name = "short_frame";
	pay.delete();
	for (int i = 0; i < 10; i++)
		pay.push_back(8'(8'ha0 + i));
	expect_frame(1'b0, ref_frame(USR_DST, MY_MAC, 16'h88b5, pay));
	send_usr(USR_DST, 16'h88b5, pay, 1'b0);
	wait_idle();

	test_name = "long_frame";
	pay = random_payload(200);
	expect_frame(1'b0, ref_frame(USR_DST, MY_MAC, 16'h88b5, pay));
	send_usr(USR_DST, 16'h88b5, pay, 1'b0);
	wait_idle();

	test_name = "arp_match";
	expect_frame(1'b1, ref_frame(PEER_MAC, MY_MAC, `ETH_ETYPE_ARP,
		arp_reply_body(PEER_MAC, PEER_IPV4)));
	send_rx(arp_request(PEER_MAC, PEER_IPV4, MY_IPV4));
	wait_idle();

	test_name = "arp_other";
	seen = frames_seen;
	send_rx(arp_request(PEER_MAC, PEER_IPV4, MY_IPV4 + 32'd1));
	repeat (150) @(negedge clk);
	if (frames_seen != seen) begin
		log_failure("a request for another IPv4 address produced a frame");
		fails++;
	end

	// both sources queued at once.
	test_name = "mixed";
	pay = random_payload(30);
	expect_frame(1'b0, ref_frame(USR_DST, MY_MAC, 16'h88b5, pay));
	expect_frame(1'b1, ref_frame(PEER_MAC, MY_MAC, `ETH_ETYPE_ARP,
		arp_reply_body(PEER_MAC, PEER_IPV4)));
	fork
		send_rx(arp_request(PEER_MAC, PEER_IPV4, MY_IPV4));
		send_usr(USR_DST, 16'h88b5, pay, 1'b0);
	join
	wait_idle();
	if (last_gap != `ETH_GAP) begin
		log_mismatch("back to back gap", 32'(`ETH_GAP), 32'(last_gap));
		mism++;
	end

	test_name = "backpressure";
	saw_stall = 1'b0;
	for (int n = 0; n < 10; n++) begin
		pay = random_payload(int'($urandom_range(24, 4)));
		expect_frame(1'b0, ref_frame(USR_DST, MY_MAC, 16'h88b6, pay));
		send_usr(USR_DST, 16'h88b6, pay, 1'b1);
	end
	wait_idle();
	if (!saw_stall) begin
		log_failure("usr_rdy never fell while the user queue was backed up");
		fails++;
	end

	test_name = "counters";
	apb_read(`REG_TX_CNT, rd, err);
	if (rd != 32'(exp_tx)) begin
		log_mismatch("tx_cnt", 32'(exp_tx), rd);
		mism++;
	end
	apb_read(`REG_ARP_CNT, rd, err);
	if (rd != 32'(exp_arp)) begin
		log_mismatch("arp_cnt", 32'(exp_arp), rd);
		mism++;
	end
	apb_read(`REG_DROP_CNT, rd, err);
	if (rd != 32'(exp_drop)) begin
		log_mismatch("drop_cnt", 32'(exp_drop), rd);
		mism++;
	end

	$display("errors: %0d value mismatches, %0d other failures, %0d frames checked",
		mism + phy_mism, fails + phy_fails, frames_seen);
	if (mism + phy_mism + fails + phy_fails == 0) begin
		$display("Test completed successfully");
	end else begin
		$display("Test failed");
	end
	$finish;
end

endmodule

`default_nettype wire
